// ==== bbc_pkg.sv ====
package bbc_pkg;

	// one cpu memory cycle, held by the core for the whole access
	typedef struct packed {
		logic [15:0] adr;
		logic [3:0]  romsel; // sideways bank from the romsel latch
		logic        we;
		logic [7:0]  wdata;
	} cpu_bus_t;

	// download loader write port
	typedef struct packed {
		logic        active;
		logic        we;
		logic [24:0] addr; // bit 24 set selects the rom store
		logic [7:0]  data;
	} loader_bus_t;

	typedef struct packed {
		logic [8:0]  zero;
		logic [15:0] adr;
	} sdram_main_t;

	typedef struct packed {
		logic [6:0]  marker; // always 1 for sideways space
		logic [3:0]  romsel;
		logic [13:0] offset;
	} sdram_sideways_t;

	// same sdram word, seen as main ram or as a sideways bank
	typedef union packed {
		sdram_main_t     main;
		sdram_sideways_t sideways;
	} sdram_addr_u;

	// request towards the external sdram controller
	typedef struct packed {
		logic        valid;
		logic        we;
		sdram_addr_u addr;
		logic [7:0]  wdata;
	} sdram_req_t;

	// control register fields, bit 0 is reset_req
	typedef struct packed {
		logic autoboot;
		logic rom_map_low; // basic in bank 0, mmfs in bank 2
		logic reset_req;
	} bbc_cfg_t;

	typedef enum logic [1:0] {
		rom_os    = 2'd0,
		rom_basic = 2'd1,
		rom_mmfs  = 2'd2
	} rom_id_t;

	// apb register offsets
	localparam logic [11:0] reg_ctrl   = 12'h000;
	localparam logic [11:0] reg_status = 12'h004;

endpackage

// ==== bbc_cfg_apb.sv ====
module bbc_cfg_apb (
	input  logic              clk_32m,
	input  logic              reset,
	input  logic [11:0]       paddr,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	output bbc_pkg::bbc_cfg_t cfg,
	input  logic              cpu_reset,
	input  logic              loader_active,
	input  logic              autoboot_shift
);

	logic ctrl_wr;

	assign pready = 1'b1; // no wait states

	// write lands in the access phase
	assign ctrl_wr = psel && penable && pwrite && (paddr == bbc_pkg::reg_ctrl);

	always_ff @(posedge clk_32m) begin
		if (reset) begin
			cfg <= '0;
		end else if (ctrl_wr) begin
			cfg <= bbc_pkg::bbc_cfg_t'(pwdata[2:0]);
		end
	end

	// read mux and error flag
	always_comb begin
		prdata  = 32'd0;
		pslverr = 1'b0;
		case (paddr)
			bbc_pkg::reg_ctrl: begin
				prdata = {29'd0, cfg};
			end
			bbc_pkg::reg_status: begin
				prdata = {29'd0, autoboot_shift, loader_active, cpu_reset}; // live bits
			end
			default: begin
				pslverr = psel && penable;
			end
		endcase
	end

endmodule

// ==== bbc_reset_ctrl.sv ====
module bbc_reset_ctrl #(
	parameter int REMAP_HOLD      = 4095,
	parameter int AUTOBOOT_CYCLES = 32000000
) (
	input  logic              clk_32m,
	input  logic              reset,
	input  logic              mem_sync,
	input  logic              sdram_ready,
	input  bbc_pkg::bbc_cfg_t cfg,
	input  logic              loader_active,
	output logic              cpu_reset,
	output logic              autoboot_shift
);

	localparam int REMAP_W = $clog2(REMAP_HOLD + 1);
	localparam int BOOT_W  = $clog2(AUTOBOOT_CYCLES + 1);

	logic               last_map;
	logic [REMAP_W-1:0] remap_cnt;
	logic [BOOT_W-1:0]  boot_cnt;
	logic               reset_in;

	// hold the core in reset for a while after the rom mapping changes
	always_ff @(posedge clk_32m) begin
		if (reset) begin
			last_map  <= 1'b0;
			remap_cnt <= '0;
		end else begin
			last_map <= cfg.rom_map_low;
			if (last_map != cfg.rom_map_low) begin
				remap_cnt <= REMAP_W'(REMAP_HOLD);
			end else if (remap_cnt != '0) begin
				remap_cnt <= remap_cnt - REMAP_W'(1);
			end
		end
	end

	assign reset_in = reset || !sdram_ready || cfg.reset_req || loader_active ||
		(remap_cnt != '0);

	// core only leaves reset on a memory cycle boundary
	always_ff @(posedge clk_32m) begin
		if (reset || mem_sync) begin
			cpu_reset <= reset_in;
		end
	end

	// shift is held down for a fixed time once the core runs
	always_ff @(posedge clk_32m) begin
		if (reset || cpu_reset) begin
			boot_cnt <= BOOT_W'(AUTOBOOT_CYCLES);
		end else if (boot_cnt != '0) begin
			boot_cnt <= boot_cnt - BOOT_W'(1);
		end
	end

	assign autoboot_shift = cfg.autoboot && (boot_cnt != '0);

endmodule

// ==== bbc_rom_store.sv ====
module bbc_rom_store #(
	parameter int ROM_AW = 14
) (
	input  logic              clk_32m,
	input  logic              wr_en,
	input  bbc_pkg::rom_id_t  wr_rom,
	input  logic [ROM_AW-1:0] wr_addr,
	input  logic [7:0]        wr_data,
	input  bbc_pkg::rom_id_t  rd_rom,
	input  logic [ROM_AW-1:0] rd_addr,
	output logic [7:0]        rd_data
);

	localparam int DEPTH = 1 << ROM_AW;

	// os, basic and mmfs images side by side
	logic [7:0] mem [3][DEPTH];

	always_ff @(posedge clk_32m) begin
		if (wr_en) begin
			mem[wr_rom][wr_addr] <= wr_data;
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge clk_32m) begin
		rd_data <= mem[rd_rom][rd_addr];
	end

endmodule

// ==== bbc_mem_map.sv ====
module bbc_mem_map #(
	parameter int ROM_AW = 14
) (
	input  logic                 clk_32m,
	input  logic                 reset,
	input  bbc_pkg::cpu_bus_t    cpu,
	input  logic                 mem_sync,
	output logic [7:0]           cpu_rdata,
	output logic                 cpu_rvalid,
	input  bbc_pkg::loader_bus_t loader,
	input  logic                 rom_map_low,
	output bbc_pkg::sdram_req_t  sdram_req,
	input  logic                 sdram_ack,
	input  logic [7:0]           sdram_rdata,
	output logic                 rom_wr_en,
	output bbc_pkg::rom_id_t     rom_wr_rom,
	output logic [ROM_AW-1:0]    rom_wr_addr,
	output logic [7:0]           rom_wr_data,
	output bbc_pkg::rom_id_t     rom_rd_rom,
	output logic [ROM_AW-1:0]    rom_rd_addr,
	input  logic [7:0]           rom_rd_data
);

	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_rom   = 2'd1;
	localparam logic [1:0] st_sdram = 2'd2;

	logic [1:0]           state;
	logic                 bank_rom, basic_hit, mmfs_hit, shadow_hit;
	logic                 os_hit, main_hit, swram_hit, rom_hit;
	logic                 use_sdram, ld_sdram, ld_done;
	logic                 rd_ff, req_cpu;
	logic                 req_valid, req_we;
	logic [7:0]           req_wdata;
	bbc_pkg::sdram_addr_u req_addr, cpu_addr;

	// bank decode, basic and mmfs move with the rom mapping
	assign bank_rom   = cpu.adr[15:14] == 2'b10;
	assign basic_hit  = bank_rom && (cpu.romsel == (rom_map_low ? 4'h0 : 4'he));
	assign mmfs_hit   = bank_rom && (cpu.romsel == (rom_map_low ? 4'h2 : 4'hc));
	assign shadow_hit = bank_rom && (cpu.romsel == 4'ha);
	assign os_hit     = cpu.adr[15:14] == 2'b11;
	assign main_hit   = !cpu.adr[15];
	assign swram_hit  = bank_rom && (cpu.romsel[3:2] == 2'b01); // banks 4 to 7
	assign rom_hit    = basic_hit || mmfs_hit || os_hit;

	// shadowed bank a is ram, so writes go through as well
	assign use_sdram = main_hit || swram_hit || shadow_hit;

	always_comb begin
		if (basic_hit) begin
			rom_rd_rom = bbc_pkg::rom_basic;
		end else if (mmfs_hit) begin
			rom_rd_rom = bbc_pkg::rom_mmfs;
		end else begin
			rom_rd_rom = bbc_pkg::rom_os;
		end
	end

	assign rom_rd_addr = cpu.adr[ROM_AW-1:0];

	always_comb begin
		if (main_hit) begin
			cpu_addr.main.zero = 9'd0;
			cpu_addr.main.adr  = cpu.adr;
		end else begin
			cpu_addr.sideways.marker = 7'd1;
			cpu_addr.sideways.romsel = cpu.romsel;
			cpu_addr.sideways.offset = cpu.adr[13:0];
		end
	end

	// loader rom writes bypass the fsm
	assign rom_wr_en   = loader.active && loader.we && loader.addr[24];
	assign rom_wr_rom  = bbc_pkg::rom_id_t'(loader.addr[15:14]);
	assign rom_wr_addr = loader.addr[ROM_AW-1:0];
	assign rom_wr_data = loader.data;

	// one request per loader write strobe
	assign ld_sdram = loader.active && loader.we && !loader.addr[24] && !ld_done;

	always_ff @(posedge clk_32m) begin
		if (reset) begin
			state      <= st_idle;
			req_valid  <= 1'b0;
			cpu_rvalid <= 1'b0;
			ld_done    <= 1'b0;
		end else begin
			cpu_rvalid <= 1'b0;
			if (!loader.we) begin
				ld_done <= 1'b0;
			end
			case (state)
				st_idle: begin
					if (ld_sdram) begin
						state     <= st_sdram;
						req_valid <= 1'b1;
						req_cpu   <= 1'b0;
						req_we    <= 1'b1;
						req_addr  <= loader.addr;
						req_wdata <= loader.data;
					end else if (mem_sync && !loader.active) begin
						if (use_sdram) begin
							state     <= st_sdram;
							req_valid <= 1'b1;
							req_cpu   <= 1'b1;
							req_we    <= cpu.we;
							req_addr  <= cpu_addr;
							req_wdata <= cpu.wdata;
						end else begin
							state <= st_rom;
							rd_ff <= cpu.we || !rom_hit; // unassigned or suppressed
						end
					end
				end
				st_rom: begin
					state      <= st_idle;
					cpu_rvalid <= 1'b1;
					cpu_rdata  <= rd_ff ? 8'hff : rom_rd_data;
				end
				st_sdram: begin
					if (sdram_ack) begin
						state      <= st_idle;
						req_valid  <= 1'b0;
						cpu_rvalid <= req_cpu;
						cpu_rdata  <= sdram_rdata;
						if (!req_cpu) begin
							ld_done <= 1'b1;
						end
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	assign sdram_req = '{valid: req_valid, we: req_we, addr: req_addr, wdata: req_wdata};

endmodule

// ==== bbc_mem_subsys.sv ====
module bbc_mem_subsys #(
	parameter int ROM_AW          = 14,
	parameter int REMAP_HOLD      = 4095,
	parameter int AUTOBOOT_CYCLES = 32000000
) (
	input  logic                 clk_32m,
	input  logic                 reset,
	input  logic [11:0]          paddr,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  bbc_pkg::cpu_bus_t    cpu,
	input  logic                 mem_sync,
	output logic [7:0]           cpu_rdata,
	output logic                 cpu_rvalid,
	output logic                 cpu_reset,
	output logic                 autoboot_shift,
	input  bbc_pkg::loader_bus_t loader,
	output bbc_pkg::sdram_req_t  sdram_req,
	input  logic                 sdram_ack,
	input  logic [7:0]           sdram_rdata,
	input  logic                 sdram_ready
);

	bbc_pkg::bbc_cfg_t cfg;
	logic              rom_wr_en;
	bbc_pkg::rom_id_t  rom_wr_rom, rom_rd_rom;
	logic [ROM_AW-1:0] rom_wr_addr, rom_rd_addr;
	logic [7:0]        rom_wr_data, rom_rd_data;

	bbc_cfg_apb cfg_apb_inst (
		.clk_32m(clk_32m), .reset(reset), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .cfg(cfg), .cpu_reset(cpu_reset),
		.loader_active(loader.active), .autoboot_shift(autoboot_shift)
	);

	bbc_reset_ctrl #(.REMAP_HOLD(REMAP_HOLD), .AUTOBOOT_CYCLES(AUTOBOOT_CYCLES)) reset_ctrl_inst (
		.clk_32m(clk_32m), .reset(reset), .mem_sync(mem_sync), .sdram_ready(sdram_ready),
		.cfg(cfg), .loader_active(loader.active), .cpu_reset(cpu_reset),
		.autoboot_shift(autoboot_shift)
	);

	bbc_rom_store #(.ROM_AW(ROM_AW)) rom_store_inst (
		.clk_32m(clk_32m), .wr_en(rom_wr_en), .wr_rom(rom_wr_rom), .wr_addr(rom_wr_addr),
		.wr_data(rom_wr_data), .rd_rom(rom_rd_rom), .rd_addr(rom_rd_addr),
		.rd_data(rom_rd_data)
	);

	// rom mapping comes straight from the control register
	bbc_mem_map #(.ROM_AW(ROM_AW)) mem_map_inst (
		.clk_32m(clk_32m), .reset(reset), .cpu(cpu), .mem_sync(mem_sync),
		.cpu_rdata(cpu_rdata), .cpu_rvalid(cpu_rvalid), .loader(loader),
		.rom_map_low(cfg.rom_map_low), .sdram_req(sdram_req), .sdram_ack(sdram_ack),
		.sdram_rdata(sdram_rdata), .rom_wr_en(rom_wr_en), .rom_wr_rom(rom_wr_rom),
		.rom_wr_addr(rom_wr_addr), .rom_wr_data(rom_wr_data), .rom_rd_rom(rom_rd_rom),
		.rom_rd_addr(rom_rd_addr), .rom_rd_data(rom_rd_data)
	);

endmodule

// ==== bbc_mem_checker.sv ====
module bbc_mem_checker #(
	parameter int ROM_AW = 8
) (
	input  logic                 clk_32m,
	input  logic                 reset,
	input  bbc_pkg::cpu_bus_t    cpu,
	input  logic                 mem_sync,
	input  logic                 rom_map_low,
	input  logic [7:0]           cpu_rdata,
	input  logic                 cpu_rvalid,
	input  bbc_pkg::loader_bus_t loader,
	input  bbc_pkg::sdram_req_t  sdram_req,
	input  logic                 sdram_ack,
	output int                   err_count
);

	typedef struct packed {
		logic [1:0]  kind; // 0 rom, 1 sdram, 2 reads as ff
		logic [24:0] addr;
		logic [7:0]  data;
	} expect_t;

	logic [7:0] rom_model [3][1 << ROM_AW];
	logic [7:0] ram_model [logic [24:0]];
	expect_t    exp_acc;
	logic       pending = 1'b0;
	logic       req_seen, exp_we;
	logic [7:0] exp_wdata;
	int         wait_cyc, ack_cyc;
	int         test_errs = 0;
	int         test_num = 0;

	initial begin
		err_count = 0;
	end

	// untouched sdram locations read back as a mix of all address bits
	function automatic logic [7:0] fill_byte(logic [24:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]};
	endfunction

	function automatic expect_t expected_read(bbc_pkg::cpu_bus_t c, logic low);
		expect_t e;
		logic    bank;
		bank = c.adr[15:14] == 2'b10;
		e    = '{kind: 2'd2, addr: {9'd0, c.adr}, data: 8'hff};
		if (bank && c.romsel == (low ? 4'h0 : 4'he)) begin
			e.kind = 2'd0;
			e.data = rom_model[1][c.adr[ROM_AW-1:0]];
		end else if (bank && c.romsel == (low ? 4'h2 : 4'hc)) begin
			e.kind = 2'd0;
			e.data = rom_model[2][c.adr[ROM_AW-1:0]];
		end else if (bank && (c.romsel == 4'ha || c.romsel[3:2] == 2'b01)) begin
			e.kind = 2'd1;
			e.addr = {7'd1, c.romsel, c.adr[13:0]}; // sideways view
		end else if (c.adr[15:14] == 2'b11) begin
			e.kind = 2'd0;
			e.data = rom_model[0][c.adr[ROM_AW-1:0]];
		end else if (!c.adr[15]) begin
			e.kind = 2'd1;
		end
		if (e.kind == 2'd1) begin
			e.data = ram_model.exists(e.addr) ? ram_model[e.addr] : fill_byte(e.addr);
		end else if (c.we) begin
			e.kind = 2'd2; // rom writes are dropped
		end
		return e;
	endfunction

	task automatic record_error(string msg);
		$display("Fail at %0t: %s", $time, msg);
		test_errs++;
		err_count++;
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			record_error($sformatf("%s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_true(string name, logic ok);
		if (ok !== 1'b1) begin
			record_error(name);
		end
	endtask

	task automatic end_test(string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, test_errs);
		test_errs = 0;
	endtask

	task automatic report_totals();
		$display("%0d tests run, %0d errors in total", test_num, err_count);
	endtask

	always @(posedge clk_32m) begin
		if (!reset && loader.active && loader.we && loader.addr[24]) begin
			rom_model[loader.addr[15:14]][loader.addr[ROM_AW-1:0]] = loader.data;
		end
		if (!reset && loader.active && loader.we && !loader.addr[24]) begin
			ram_model[loader.addr] = loader.data; // loader writes straight to sdram
		end
		if (reset) begin
			pending = 1'b0;
		end else if (mem_sync && !loader.active) begin
			exp_acc   = expected_read(cpu, rom_map_low);
			exp_we    = cpu.we;
			exp_wdata = cpu.wdata;
			pending   = 1'b1;
			req_seen  = 1'b0;
			wait_cyc  = 0;
			ack_cyc   = -1;
			if (cpu.we && exp_acc.kind == 2'd1) begin
				ram_model[exp_acc.addr] = cpu.wdata;
			end
		end else if (pending) begin
			wait_cyc++;
			if (sdram_req.valid && !req_seen) begin
				req_seen = 1'b1;
				if (exp_acc.kind != 2'd1) begin
					record_error($sformatf("unexpected sdram request for %h", cpu.adr));
				end else begin
					check_value("sdram addr", 32'(sdram_req.addr), 32'(exp_acc.addr));
					check_value("sdram we", 32'(sdram_req.we), 32'(exp_we));
					if (exp_we) begin
						check_value("sdram wdata", 32'(sdram_req.wdata), 32'(exp_wdata));
					end
				end
			end
			if (sdram_req.valid && sdram_ack) begin
				ack_cyc = wait_cyc;
			end
			if (cpu_rvalid) begin
				pending = 1'b0;
				if (exp_acc.kind == 2'd1) begin
					check_true("sdram request missing", req_seen);
					check_value("rvalid after ack", 32'(wait_cyc - ack_cyc), 32'd1);
				end else begin
					check_value("rvalid latency", 32'(wait_cyc), 32'd2);
				end
				if (!exp_we) begin
					check_value($sformatf("read %h bank %h", cpu.adr, cpu.romsel),
						32'(cpu_rdata), 32'(exp_acc.data));
				end
			end
		end else if (cpu_rvalid) begin
			record_error("cpu_rvalid seen with no access open");
		end
	end

endmodule

// ==== tb_bbc_mem_subsys.sv ====
module tb_bbc_mem_subsys;

	localparam int ROM_AW          = 8;
	localparam int REMAP_HOLD      = 20;
	localparam int AUTOBOOT_CYCLES = 50;
	localparam int N_ACC           = 40;
	// loader fill, three access passes at up to 8 cycles each, two reset runs, doubled
	localparam int TIMEOUT_CYCLES = 2 * (3 * (1 << ROM_AW) + 3 * N_ACC * 8 +
		2 * (REMAP_HOLD + AUTOBOOT_CYCLES));

	logic                 clk_32m, reset, psel, penable, pwrite, pready, pslverr;
	logic [11:0]          paddr;
	logic [31:0]          pwdata, prdata;
	bbc_pkg::cpu_bus_t    cpu;
	logic                 mem_sync, cpu_rvalid, cpu_reset, autoboot_shift;
	logic [7:0]           cpu_rdata, sdram_rdata;
	bbc_pkg::loader_bus_t loader;
	bbc_pkg::sdram_req_t  sdram_req;
	logic                 sdram_ack, sdram_ready;
	logic                 map_low = 1'b0;
	logic [7:0]           sdram_mem [logic [24:0]];
	bbc_pkg::sdram_req_t  req_log [$];
	logic [24:0]          req_addr;
	int                   ack_wait = 0;
	int                   cycle = 0;
	int                   shift_cnt = 0;
	int                   err_count;

	bbc_mem_subsys #(.ROM_AW(ROM_AW), .REMAP_HOLD(REMAP_HOLD),
		.AUTOBOOT_CYCLES(AUTOBOOT_CYCLES)) bbc_mem_subsys_inst (.*);

	bbc_mem_checker #(.ROM_AW(ROM_AW)) checker_inst (
		.clk_32m(clk_32m), .reset(reset), .cpu(cpu), .mem_sync(mem_sync),
		.rom_map_low(map_low), .cpu_rdata(cpu_rdata), .cpu_rvalid(cpu_rvalid),
		.loader(loader), .sdram_req(sdram_req), .sdram_ack(sdram_ack), .err_count(err_count)
	);

	initial begin
		clk_32m = 1'b0;
		forever #5 clk_32m = ~clk_32m;
	end

	assign req_addr = sdram_req.addr;

	// sdram controller model, ack after 0 to 3 wait cycles
	always @(posedge clk_32m) begin
		sdram_ack <= 1'b0;
		if (sdram_req.valid && !sdram_ack) begin
			if (ack_wait != 0) begin
				ack_wait <= ack_wait - 1;
			end else begin
				sdram_ack <= 1'b1;
				ack_wait  <= $urandom_range(3, 0);
				req_log.push_back(sdram_req);
				if (sdram_req.we) begin
					sdram_mem[req_addr] = sdram_req.wdata;
				end else if (sdram_mem.exists(req_addr)) begin
					sdram_rdata <= sdram_mem[req_addr];
				end else begin
					sdram_rdata <= req_addr[7:0] ^ req_addr[15:8] ^ req_addr[23:16] ^
						{7'd0, req_addr[24]};
				end
			end
		end
	end

	always @(posedge clk_32m) begin
		cycle <= cycle + 1;
		if (cpu_reset) begin
			shift_cnt <= 0;
		end else if (autoboot_shift) begin
			shift_cnt <= shift_cnt + 1; // high cycles since the core left reset
		end
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycle);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk_32m);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk_32m);
		penable <= 1'b1;
		@(posedge clk_32m);
		rdata = prdata; // access phase values
		err   = pslverr;
		checker_inst.check_true("pready low in access phase", pready);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic set_ctrl(input logic [31:0] val);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, bbc_pkg::reg_ctrl, val, rd, err);
		map_low <= val[1];
	endtask

	task automatic cpu_access(input logic [15:0] addr, input logic [3:0] sel, input logic wr,
		input logic [7:0] data);
		@(posedge clk_32m);
		cpu      <= '{adr: addr, romsel: sel, we: wr, wdata: data};
		mem_sync <= 1'b1;
		@(posedge clk_32m);
		mem_sync <= 1'b0;
		@(posedge clk_32m);
		while (!cpu_rvalid) begin
			@(posedge clk_32m);
		end
	endtask

	task automatic rom_write(input logic [1:0] id, input logic [ROM_AW-1:0] off,
		input logic [7:0] data);
		@(posedge clk_32m);
		loader <= '{active: 1'b1, we: 1'b1, addr: 25'h1000000 | (25'(id) << 14) | 25'(off),
			data: data};
	endtask

	// loader write to main ram, held until the controller acks it
	task automatic sdram_load(input logic [15:0] adr, input logic [7:0] data);
		@(posedge clk_32m);
		loader <= '{active: 1'b1, we: 1'b1, addr: 25'(adr), data: data};
		@(posedge clk_32m);
		while (!(sdram_req.valid && sdram_ack)) begin
			@(posedge clk_32m);
		end
		loader.we <= 1'b0;
	endtask

	initial begin
		logic [31:0] rd;
		logic        err, rose;
		logic [15:0] a;
		logic [15:0] written [$];
		logic [15:0] ld_addr [4];
		int          t0;
		void'($urandom(32'h381c4024));
		reset       = 1'b1;
		{psel, penable, pwrite, paddr, pwdata} = '0;
		cpu         = '0;
		mem_sync    = 1'b0;
		loader      = '0;
		sdram_ack   = 1'b0;
		sdram_rdata = 8'h00;
		sdram_ready = 1'b1;
		repeat (4) @(posedge clk_32m);
		reset <= 1'b0;

		apb_access(1'b0, bbc_pkg::reg_status, 32'd0, rd, err);
		checker_inst.check_value("status after reset", rd, 32'h1); // only cpu_reset set
		set_ctrl(32'h4);
		apb_access(1'b0, bbc_pkg::reg_ctrl, 32'd0, rd, err);
		checker_inst.check_value("ctrl readback", rd, 32'h4);
		apb_access(1'b0, 12'h008, 32'd0, rd, err);
		checker_inst.check_true("no pslverr on unmapped read", err);
		checker_inst.end_test("apb registers");

		repeat (N_ACC) begin
			if ($urandom_range(1, 0) == 1 || written.size() == 0) begin
				a = 16'($urandom_range(16'h7fff, 0));
				written.push_back(a);
				cpu_access(a, 4'($urandom), 1'b1, 8'($urandom));
			end else begin
				cpu_access(written[$urandom_range(written.size() - 1, 0)], 4'h0, 1'b0, 8'h00);
			end
		end
		checker_inst.end_test("main ram");

		// every bank, rom banks still unloaded so only written back where readable
		for (int s = 0; s < 16; s++) begin
			a = 16'h8000 | 16'($urandom_range(16'h3fff, 0));
			cpu_access(a, 4'(s), 1'b1, 8'($urandom));
			if (s != 14 && s != 12) begin
				cpu_access(a, 4'(s), 1'b0, 8'h00);
			end
		end
		cpu_access(16'hc123, 4'h0, 1'b1, 8'h5a);
		checker_inst.end_test("sideways ram");

		for (int id = 0; id < 3; id++) begin
			for (int off = 0; off < (1 << ROM_AW); off++) begin
				rom_write(2'(id), ROM_AW'(off), 8'($urandom));
			end
		end
		for (int i = 0; i < 4; i++) begin
			ld_addr[i] = 16'($urandom_range(16'h7fff, 0));
			sdram_load(ld_addr[i], 8'($urandom));
		end
		@(posedge clk_32m);
		loader <= '0;
		foreach (ld_addr[i]) begin
			cpu_access(ld_addr[i], 4'h0, 1'b0, 8'h00);
		end
		checker_inst.end_test("loader sdram writes");

		for (int m = 0; m < 2; m++) begin
			set_ctrl({29'd0, 1'b1, 1'(m), 1'b0});
			repeat (N_ACC / 4) begin
				cpu_access(16'hc000 | 16'($urandom_range(16'h3fff, 0)), 4'h0, 1'b0, 8'h00);
				cpu_access(16'h8000 | 16'($urandom_range(16'h3fff, 0)), m ? 4'h0 : 4'he,
					1'b0, 8'h00);
				cpu_access(16'h8000 | 16'($urandom_range(16'h3fff, 0)), m ? 4'h2 : 4'hc,
					1'b0, 8'h00);
			end
		end
		checker_inst.end_test("rom images");

		t0 = cycle;
		set_ctrl(32'h4); // map back to high banks, autoboot on
		cpu_access(16'h8000, 4'h9, 1'b0, 8'h00);
		rose = cpu_reset;
		while (cpu_reset) begin
			cpu_access(16'h8000, 4'h9, 1'b0, 8'h00);
		end
		checker_inst.check_true("cpu_reset not raised by remap", rose);
		checker_inst.check_true("cpu_reset released early", cycle - t0 >= REMAP_HOLD);
		while (autoboot_shift) begin
			@(posedge clk_32m);
		end
		checker_inst.check_true("autoboot shift length wrong",
			shift_cnt >= AUTOBOOT_CYCLES && shift_cnt <= AUTOBOOT_CYCLES + 1);
		apb_access(1'b0, bbc_pkg::reg_status, 32'd0, rd, err);
		checker_inst.check_value("status with core running", rd, 32'h0);
		checker_inst.end_test("reset control");

		checker_inst.report_totals();
		$display("sdram requests served: %0d", req_log.size());
		if (err_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== bbc_mem_subsys.f ====
bbc_pkg.sv
bbc_cfg_apb.sv
bbc_reset_ctrl.sv
bbc_rom_store.sv
bbc_mem_map.sv
bbc_mem_subsys.sv
bbc_mem_checker.sv
tb_bbc_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/bash
# build with verilator, run, then look for the fail line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_bbc_mem_subsys \
	-f bbc_mem_subsys.f -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || grep -q "Result: PASSED" sim.log && exit 0 || exit 1
